// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  localparam int dataWidth    = 16;
  localparam int regAddrWidth = 4;
  localparam int imemDepth    = 256;
  localparam int dmemDepth    = 256;

  // JAL return address register
  localparam logic [regAddrWidth-1:0] linkReg = 4'd15;

  // Opcodes 0..7 line up with the ALU operations below
  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opNor  = 4'h3,
    opSll  = 4'h4,
    opSrl  = 4'h5,
    opLlb  = 4'h6,
    opLhb  = 4'h7,
    opLw   = 4'h8,
    opSw   = 4'h9,
    opB    = 4'hA,
    opJal  = 4'hB,
    opJr   = 4'hC,
    opHlt  = 4'hD,
    opNop0 = 4'hE,
    opNop1 = 4'hF
  } opcode_t;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluNor, aluSll, aluSrl, aluLlb, aluLhb
  } aluOp_t;

  typedef enum logic [2:0] {
    condNe, condEq, condGt, condLt, condGe, condLe, condOv, condAlways
  } branchCond_t;

  // Register view for most opcodes, jump view for JAL and B offsets
  typedef union packed {
    struct packed {
      opcode_t     opcode;
      logic [3:0]  rd;
      logic [3:0]  rs;
      logic [3:0]  rt;
    } fields;
    struct packed {
      opcode_t     opcode;
      logic [11:0] offset;
    } jump;
  } instrWord_t;

endpackage

`default_nettype wire

// ==== fetch/instrFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrFetch import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 hlt,
  input  logic                 branchTaken,
  input  logic [dataWidth-1:0] branchTarget,
  output logic [dataWidth-1:0] pc,
  output instrWord_t           instr,
  output logic [dataWidth-1:0] pcNext,
  output logic                 instrValid
);

  logic [dataWidth-1:0] rom [imemDepth];
  logic [dataWidth-1:0] pcPlusOne;

  initial $readmemh("program.hex", rom);

  assign pcPlusOne = pc + dataWidth'(1);

  // Program counter, frozen once the core halts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= '0;
      instrValid <= 1'b0;
    end else if (hlt) begin
      instrValid <= 1'b0;
    end else begin
      pc         <= branchTaken ? branchTarget : pcPlusOne;
      instrValid <= 1'b1;
    end
  end

  // ****************************************
  // Fetch/decode register
  // ****************************************
  always_ff @(posedge clk) begin
    instr  <= rom[pc[$clog2(imemDepth)-1:0]];
    pcNext <= pcPlusOne;
  end

endmodule

`default_nettype wire

// ==== decode/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [regAddrWidth-1:0] rsAddr,
  input  logic [regAddrWidth-1:0] rtAddr,
  output logic [dataWidth-1:0]    rsData,
  output logic [dataWidth-1:0]    rtData,
  input  logic                    writeEnable,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]    writeData
);

  logic [dataWidth-1:0] regs [1 << regAddrWidth];

  // R0 is hardwired, a same-cycle write is bypassed to the reader
  function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (writeEnable && (writeAddr == addr)) begin
      return writeData;
    end
    return regs[addr];
  endfunction

  always_comb rsData = readPort(rsAddr);
  always_comb rtData = readPort(rtAddr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < (1 << regAddrWidth); i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== decode/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  instrWord_t              instr,
  input  logic [dataWidth-1:0]    pcNext,
  input  logic                    instrValid,
  input  logic                    writeEnable,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]    writeData,
  output logic [dataWidth-1:0]    rsDataEx,
  output logic [dataWidth-1:0]    rtDataEx,
  output logic [dataWidth-1:0]    immEx,
  output logic [dataWidth-1:0]    pcNextEx,
  output aluOp_t                  aluOpEx,
  output logic                    aluSrcImmEx,
  output logic                    regWeEx,
  output logic                    memReEx,
  output logic                    memWeEx,
  output logic                    memToRegEx,
  output logic                    isBranchEx,
  output logic                    isJalEx,
  output logic                    isJrEx,
  output logic                    isHltEx,
  output logic                    flagEnZEx,
  output logic                    flagEnNVEx,
  output logic [regAddrWidth-1:0] destAddrEx,
  output branchCond_t             condEx
);

  opcode_t                 opcode;
  logic [regAddrWidth-1:0] rsAddr;
  logic [regAddrWidth-1:0] rtAddr;
  logic [dataWidth-1:0]    rsData;
  logic [dataWidth-1:0]    rtData;
  logic [dataWidth-1:0]    imm;
  logic [7:0]              imm8;

  assign opcode = instr.fields.opcode;
  assign imm8   = {instr.fields.rs, instr.fields.rt};

  // LHB merges into the old rd value, SW stores rd
  assign rsAddr = (opcode == opLhb) ? instr.fields.rd : instr.fields.rs;
  assign rtAddr = (opcode == opSw) ? instr.fields.rd : instr.fields.rt;

  regFile u_regFile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rsAddr     (rsAddr),
    .rtAddr     (rtAddr),
    .rsData     (rsData),
    .rtData     (rtData),
    .writeEnable(writeEnable),
    .writeAddr  (writeAddr),
    .writeData  (writeData)
  );

  // Immediate by opcode
  always_comb begin
    unique case (opcode)
      opSll, opSrl: imm = {12'b0, instr.fields.rt};
      opLlb:        imm = {{8{imm8[7]}}, imm8};
      opLhb:        imm = {8'b0, imm8};
      opLw, opSw:   imm = {{12{instr.fields.rt[3]}}, instr.fields.rt};
      opB, opJal:   imm = {4'b0, instr.jump.offset};
      default:      imm = '0;
    endcase
  end

  // ****************************************
  // Decode/execute register
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regWeEx    <= 1'b0;
      memReEx    <= 1'b0;
      memWeEx    <= 1'b0;
      isBranchEx <= 1'b0;
      isJalEx    <= 1'b0;
      isJrEx     <= 1'b0;
      isHltEx    <= 1'b0;
      flagEnZEx  <= 1'b0;
      flagEnNVEx <= 1'b0;
    end else begin
      // Arithmetic opcodes are the whole lower half
      regWeEx    <= instrValid & (~opcode[3] | (opcode == opLw) | (opcode == opJal));
      memReEx    <= instrValid & (opcode == opLw);
      memWeEx    <= instrValid & (opcode == opSw);
      isBranchEx <= instrValid & (opcode == opB);
      isJalEx    <= instrValid & (opcode == opJal);
      isJrEx     <= instrValid & (opcode == opJr);
      isHltEx    <= instrValid & (opcode == opHlt);
      flagEnZEx  <= instrValid & (opcode inside {opAdd, opSub, opAnd, opNor, opSll, opSrl});
      flagEnNVEx <= instrValid & (opcode inside {opAdd, opSub});
    end
  end

  always_ff @(posedge clk) begin
    rsDataEx    <= rsData;
    rtDataEx    <= rtData;
    immEx       <= imm;
    pcNextEx    <= pcNext;
    aluOpEx     <= opcode[3] ? aluAdd : aluOp_t'(opcode[2:0]);
    aluSrcImmEx <= opcode inside {opSll, opSrl, opLlb, opLhb, opLw, opSw};
    memToRegEx  <= (opcode == opLw);
    destAddrEx  <= (opcode == opJal) ? linkReg : instr.fields.rd;
    // Condition sits in the upper three rd bits
    condEx      <= branchCond_t'(instr.fields.rd[3:1]);
  end

endmodule

`default_nettype wire

// ==== execute/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [dataWidth-1:0]    rsDataEx,
  input  logic [dataWidth-1:0]    rtDataEx,
  input  logic [dataWidth-1:0]    immEx,
  input  logic [dataWidth-1:0]    pcNextEx,
  input  aluOp_t                  aluOpEx,
  input  logic                    aluSrcImmEx,
  input  logic                    regWeEx,
  input  logic                    memReEx,
  input  logic                    memWeEx,
  input  logic                    memToRegEx,
  input  logic                    isBranchEx,
  input  logic                    isJalEx,
  input  logic                    isJrEx,
  input  logic                    isHltEx,
  input  logic                    flagEnZEx,
  input  logic                    flagEnNVEx,
  input  logic [regAddrWidth-1:0] destAddrEx,
  input  branchCond_t             condEx,
  output logic [dataWidth-1:0]    aluResultMem,
  output logic [dataWidth-1:0]    storeDataMem,
  output logic [dataWidth-1:0]    branchTargetMem,
  output logic [dataWidth-1:0]    jumpTargetMem,
  output logic [dataWidth-1:0]    jrTargetMem,
  output logic                    zInMem,
  output logic                    nInMem,
  output logic                    vInMem,
  output logic                    regWeMem,
  output logic                    memReMem,
  output logic                    memWeMem,
  output logic                    memToRegMem,
  output logic                    isBranchMem,
  output logic                    isJalMem,
  output logic                    isJrMem,
  output logic                    isHltMem,
  output logic                    flagEnZMem,
  output logic                    flagEnNVMem,
  output logic [regAddrWidth-1:0] destAddrMem,
  output branchCond_t             condMem
);

  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] aluOut;
  logic                 vIn;

  assign opB = aluSrcImmEx ? immEx : rtDataEx;

  always_comb begin
    unique case (aluOpEx)
      aluAdd:  aluOut = rsDataEx + opB;
      aluSub:  aluOut = rsDataEx - opB;
      aluAnd:  aluOut = rsDataEx & opB;
      aluNor:  aluOut = ~(rsDataEx | opB);
      aluSll:  aluOut = rsDataEx << opB[3:0];
      aluSrl:  aluOut = rsDataEx >> opB[3:0];
      aluLlb:  aluOut = opB;
      default: aluOut = {opB[7:0], rsDataEx[7:0]};
    endcase
  end

  // Signed overflow only applies to add and sub
  always_comb begin
    vIn = 1'b0;
    if (aluOpEx == aluAdd) begin
      vIn = (rsDataEx[dataWidth-1] == opB[dataWidth-1]) &&
            (aluOut[dataWidth-1] != rsDataEx[dataWidth-1]);
    end else if (aluOpEx == aluSub) begin
      vIn = (rsDataEx[dataWidth-1] != opB[dataWidth-1]) &&
            (aluOut[dataWidth-1] != rsDataEx[dataWidth-1]);
    end
  end

  // ****************************************
  // Execute/memory register
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regWeMem    <= 1'b0;
      memReMem    <= 1'b0;
      memWeMem    <= 1'b0;
      isBranchMem <= 1'b0;
      isJalMem    <= 1'b0;
      isJrMem     <= 1'b0;
      isHltMem    <= 1'b0;
      flagEnZMem  <= 1'b0;
      flagEnNVMem <= 1'b0;
    end else begin
      regWeMem    <= regWeEx;
      memReMem    <= memReEx;
      memWeMem    <= memWeEx;
      isBranchMem <= isBranchEx;
      isJalMem    <= isJalEx;
      isJrMem     <= isJrEx;
      isHltMem    <= isHltEx;
      flagEnZMem  <= flagEnZEx;
      flagEnNVMem <= flagEnNVEx;
    end
  end

  always_ff @(posedge clk) begin
    // JAL retires its return address
    aluResultMem    <= isJalEx ? pcNextEx : aluOut;
    storeDataMem    <= rtDataEx;
    branchTargetMem <= pcNextEx + {{7{immEx[8]}}, immEx[8:0]};
    jumpTargetMem   <= pcNextEx + {{4{immEx[11]}}, immEx[11:0]};
    jrTargetMem     <= rsDataEx;
    zInMem          <= (aluOut == '0);
    nInMem          <= aluOut[dataWidth-1];
    vInMem          <= vIn;
    memToRegMem     <= memToRegEx;
    destAddrMem     <= destAddrEx;
    condMem         <= condEx;
  end

endmodule

`default_nettype wire

// ==== memory/memAccess.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccess import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [dataWidth-1:0]    aluResultMem,
  input  logic [dataWidth-1:0]    storeDataMem,
  input  logic [dataWidth-1:0]    branchTargetMem,
  input  logic [dataWidth-1:0]    jumpTargetMem,
  input  logic [dataWidth-1:0]    jrTargetMem,
  input  logic                    zInMem,
  input  logic                    nInMem,
  input  logic                    vInMem,
  input  logic                    regWeMem,
  input  logic                    memReMem,
  input  logic                    memWeMem,
  input  logic                    memToRegMem,
  input  logic                    isBranchMem,
  input  logic                    isJalMem,
  input  logic                    isJrMem,
  input  logic                    isHltMem,
  input  logic                    flagEnZMem,
  input  logic                    flagEnNVMem,
  input  logic [regAddrWidth-1:0] destAddrMem,
  input  branchCond_t             condMem,
  output logic                    branchTaken,
  output logic [dataWidth-1:0]    branchTarget,
  output logic                    hlt,
  output logic                    writeEnable,
  output logic [regAddrWidth-1:0] writeAddr,
  output logic [dataWidth-1:0]    writeData
);

  logic [dataWidth-1:0]         ram [dmemDepth];
  logic [$clog2(dmemDepth)-1:0] ramAddr;
  logic [dataWidth-1:0]         loadData;
  logic                         flagZ;
  logic                         flagN;
  logic                         flagV;
  logic                         condMet;
  logic                         live;

  // Everything younger than HLT is squashed here
  assign live = ~hlt;

  assign ramAddr  = aluResultMem[$clog2(dmemDepth)-1:0];
  assign loadData = memReMem ? ram[ramAddr] : '0;

  always_ff @(posedge clk) begin
    if (live && memWeMem) begin
      ram[ramAddr] <= storeDataMem;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flagZ <= 1'b0;
      flagN <= 1'b0;
      flagV <= 1'b0;
    end else if (live) begin
      if (flagEnZMem) begin
        flagZ <= zInMem;
      end
      if (flagEnNVMem) begin
        flagN <= nInMem;
        flagV <= vInMem;
      end
    end
  end

  // Branch condition on the held flags
  always_comb begin
    unique case (condMem)
      condNe:  condMet = ~flagZ;
      condEq:  condMet = flagZ;
      condGt:  condMet = ~flagZ & ~flagN;
      condLt:  condMet = flagN;
      condGe:  condMet = flagZ | ~flagN;
      condLe:  condMet = flagZ | flagN;
      condOv:  condMet = flagV;
      default: condMet = 1'b1;
    endcase
  end

  assign branchTaken = live & ((isBranchMem & condMet) | isJalMem | isJrMem);

  always_comb begin
    if (isJrMem) begin
      branchTarget = jrTargetMem;
    end else if (isJalMem) begin
      branchTarget = jumpTargetMem;
    end else begin
      branchTarget = branchTargetMem;
    end
  end

  // ****************************************
  // Memory/writeback register
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hlt         <= 1'b0;
      writeEnable <= 1'b0;
    end else begin
      hlt         <= hlt | isHltMem;
      writeEnable <= live & regWeMem;
    end
  end

  always_ff @(posedge clk) begin
    writeAddr <= destAddrMem;
    writeData <= memToRegMem ? loadData : aluResultMem;
  end

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic                    hlt,
  output logic [dataWidth-1:0]    pc,
  output logic                    retireValid,
  output logic [regAddrWidth-1:0] retireAddr,
  output logic [dataWidth-1:0]    retireData
);

  // Fetch stage
  instrWord_t           instr;
  logic [dataWidth-1:0] pcNext;
  logic                 instrValid;
  logic                 branchTaken;
  logic [dataWidth-1:0] branchTarget;

  // Decode/execute register
  logic [dataWidth-1:0]    rsDataEx, rtDataEx, immEx, pcNextEx;
  aluOp_t                  aluOpEx;
  logic                    aluSrcImmEx, regWeEx, memReEx, memWeEx, memToRegEx;
  logic                    isBranchEx, isJalEx, isJrEx, isHltEx;
  logic                    flagEnZEx, flagEnNVEx;
  logic [regAddrWidth-1:0] destAddrEx;
  branchCond_t             condEx;

  // Execute/memory register
  logic [dataWidth-1:0]    aluResultMem, storeDataMem;
  logic [dataWidth-1:0]    branchTargetMem, jumpTargetMem, jrTargetMem;
  logic                    zInMem, nInMem, vInMem;
  logic                    regWeMem, memReMem, memWeMem, memToRegMem;
  logic                    isBranchMem, isJalMem, isJrMem, isHltMem;
  logic                    flagEnZMem, flagEnNVMem;
  logic [regAddrWidth-1:0] destAddrMem;
  branchCond_t             condMem;

  instrFetch u_fetch (.*);

  // Writeback port doubles as the retire port
  instrDecode u_decode (
    .writeEnable(retireValid),
    .writeAddr  (retireAddr),
    .writeData  (retireData),
    .*
  );

  execute u_execute (.*);

  memAccess u_memAccess (
    .writeEnable(retireValid),
    .writeAddr  (retireAddr),
    .writeData  (retireData),
    .*
  );

endmodule

`default_nettype wire

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        hlt;
  logic [15:0] pc;
  logic        retireValid;
  logic [3:0]  retireAddr;
  logic [15:0] retireData;

  // Reference model state
  logic [15:0] progMem [256];
  logic [15:0] regsM [16];
  logic [15:0] dmemM [256];
  logic        zF;
  logic        nF;
  logic        vF;
  logic [3:0]  expAddr [$];
  logic [15:0] expData [$];
  int          modelSteps = 0;
  logic        modelDone = 1'b0;

  int          retireIdx = 0;
  int          resetErrors = 0;
  int          retireErrors = 0;
  int          haltErrors = 0;
  int          memErrors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  logic [15:0] heldPc;

  cpu u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .hlt        (hlt),
    .pc         (pc),
    .retireValid(retireValid),
    .retireAddr (retireAddr),
    .retireData (retireData)
  );

  always #20 clk = ~clk;

  // ****************************************
  // ISA reference model
  // ****************************************
  function automatic logic [15:0] readReg(input logic [3:0] idx);
    return (idx == 4'd0) ? 16'h0 : regsM[idx];
  endfunction

  function automatic void recordWrite(input logic [3:0] idx, input logic [15:0] val);
    expAddr.push_back(idx);
    expData.push_back(val);
    if (idx != 4'd0) begin
      regsM[idx] = val;
    end
  endfunction

  function automatic logic condHolds(input logic [2:0] cond);
    case (cond)
      3'd0:    return !zF;
      3'd1:    return zF;
      3'd2:    return !zF && !nF;
      3'd3:    return nF;
      3'd4:    return zF || !nF;
      3'd5:    return zF || nF;
      3'd6:    return vF;
      default: return 1'b1;
    endcase
  endfunction

  task automatic runReferenceModel();
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic [15:0] pcM;
    logic [15:0] target;
    logic [15:0] pendTarget;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs;
    logic [3:0]  rt;
    logic        taken;
    logic        pending;
    logic        halted;
    int          slots;
    $readmemh("program.hex", progMem);
    for (int k = 0; k < 16; k++) begin
      regsM[k] = 16'h0;
    end
    for (int k = 0; k < 256; k++) begin
      dmemM[k] = 16'h0;
    end
    zF = 1'b0;
    nF = 1'b0;
    vF = 1'b0;
    pcM = 16'h0;
    pendTarget = 16'h0;
    pending = 1'b0;
    halted = 1'b0;
    slots = 0;
    while (!halted && modelSteps < 1000) begin
      w = progMem[pcM[7:0]];
      op = w[15:12];
      rd = w[11:8];
      rs = w[7:4];
      rt = w[3:0];
      a = readReg(rs);
      b = readReg(rt);
      taken = 1'b0;
      target = 16'h0;
      modelSteps++;
      case (op)
        4'h0, 4'h1: begin
          r = (op == 4'h0) ? a + b : a - b;
          recordWrite(rd, r);
          zF = (r == 16'h0);
          nF = r[15];
          // Signed overflow for add and subtract
          if (op == 4'h0) begin
            vF = (a[15] == b[15]) && (r[15] != a[15]);
          end else begin
            vF = (a[15] != b[15]) && (r[15] != a[15]);
          end
        end
        4'h2, 4'h3, 4'h4, 4'h5: begin
          case (op)
            4'h2:    r = a & b;
            4'h3:    r = ~(a | b);
            4'h4:    r = a << rt;
            default: r = a >> rt;
          endcase
          recordWrite(rd, r);
          zF = (r == 16'h0);
        end
        4'h6: recordWrite(rd, {{8{w[7]}}, w[7:0]});
        4'h7: begin
          r = readReg(rd);
          recordWrite(rd, {w[7:0], r[7:0]});
        end
        4'h8: begin
          r = a + {{12{rt[3]}}, rt};
          recordWrite(rd, dmemM[r[7:0]]);
        end
        4'h9: begin
          r = a + {{12{rt[3]}}, rt};
          dmemM[r[7:0]] = readReg(rd);
        end
        4'hA: begin
          taken = condHolds(rd[3:1]);
          target = pcM + 16'd1 + {{7{w[8]}}, w[8:0]};
        end
        4'hB: begin
          recordWrite(4'd15, pcM + 16'd1);
          taken = 1'b1;
          target = pcM + 16'd1 + {{4{w[11]}}, w[11:0]};
        end
        4'hC: begin
          taken = 1'b1;
          target = a;
        end
        4'hD: halted = 1'b1;
        default: ;
      endcase
      // Three delay slots before a redirect lands
      if (pending) begin
        slots--;
        if (slots == 0) begin
          pending = 1'b0;
          pcM = pendTarget;
        end else begin
          pcM = pcM + 16'd1;
        end
      end else if (taken) begin
        pending = 1'b1;
        slots = 3;
        pendTarget = target;
        pcM = pcM + 16'd1;
      end else begin
        pcM = pcM + 16'd1;
      end
    end
    if (!halted) begin
      $display("reference model never reached HLT");
      retireErrors++;
    end
  endtask

  task automatic reportTest(input string name, input int errs);
    testsRun++;
    if (errs != 0) begin
      testsFailed++;
    end
    $display("%s: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // ****************************************
  // Retire stream checker
  // ****************************************
  always @(negedge clk) begin
    if (rst_n && retireValid) begin
      assert (retireIdx < expAddr.size())
      else begin
        $display("%0t: retire strobe for R%0d beyond the expected write list",
                 $time, retireAddr);
        retireErrors++;
      end
      if (retireIdx < expAddr.size()) begin
        assert (retireAddr == expAddr[retireIdx] && retireData == expData[retireIdx])
        else begin
          $display("mismatch at %0t: write %0d got R%0d=%h, expected R%0d=%h", $time,
                   retireIdx, retireAddr, retireData, expAddr[retireIdx],
                   expData[retireIdx]);
          retireErrors++;
        end
      end
      retireIdx++;
    end
  end

  // Watchdog sized from the model's instruction count
  initial begin
    wait (modelDone);
    repeat (4 * modelSteps + 50) @(posedge clk);
    $display("watchdog expired before the core halted");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    runReferenceModel();
    modelDone = 1'b1;

    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      assert (!retireValid && !hlt && pc == 16'h0)
      else begin
        $display("mismatch at %0t: in reset retireValid=%b hlt=%b pc=%h", $time,
                 retireValid, hlt, pc);
        resetErrors++;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      assert (!retireValid && !hlt)
      else begin
        $display("mismatch at %0t: after reset retireValid=%b hlt=%b", $time,
                 retireValid, hlt);
        resetErrors++;
      end
    end
    reportTest("reset", resetErrors);

    wait (hlt === 1'b1);
    @(negedge clk);
    heldPc = pc;
    // Core must stay frozen and silent
    repeat (8) begin
      @(negedge clk);
      assert (hlt && pc == heldPc && !retireValid)
      else begin
        $display("mismatch at %0t: after halt hlt=%b pc=%h (held %h) retireValid=%b",
                 $time, hlt, pc, heldPc, retireValid);
        haltErrors++;
      end
    end
    assert (retireIdx == expAddr.size())
    else begin
      $display("mismatch at %0t: %0d retire strobes, expected %0d", $time, retireIdx,
               expAddr.size());
      retireErrors++;
    end
    reportTest("retire stream", retireErrors);
    reportTest("halt", haltErrors);

    for (int k = 0; k < 256; k++) begin
      assert (u_dut.u_memAccess.ram[k] === dmemM[k])
      else begin
        $display("mismatch at %0t: data memory[%0d]=%h, expected %h", $time, k,
                 u_dut.u_memAccess.ram[k], dmemM[k]);
        memErrors++;
      end
    end
    reportTest("data memory", memErrors);

    $display("tests run %0d, failed %0d, retired writes %0d", testsRun, testsFailed,
             retireIdx);
    if (testsFailed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/program.hex ====
// One instruction word per line: opcode, rd, rs, rt nibbles
// Addresses 0 to 38 in order, producers stay at least three ahead of consumers
6105 // 0  LLB R1, 5
627F // 1  LLB R2, 0x7F
63FF // 2  LLB R3, -1
6480 // 3  LLB R4, 0x80
0512 // 4  ADD R5 = R1 + R2
7240 // 5  LHB R2, 0x40
1613 // 6  SUB R6 = R1 - R3
2751 // 7  AND R7 = R5 & R1
3813 // 8  NOR R8 = R1 nor R3
4952 // 9  SLL R9 = R5 << 2
5A23 // 10 SRL R10 = R2 >> 3
0013 // 11 ADD R0 = R1 + R3, discarded
0B02 // 12 ADD R11 = R0 + R2
0C22 // 13 ADD R12 = R2 + R2, signed overflow
AC04 // 14 B OV to 19
0D15 // 15 ADD R13 = R1 + R5
E000 // 16 NOP
E000 // 17 NOP
6E01 // 18 LLB R14, 1 skipped
A201 // 19 B EQ not taken
9215 // 20 SW R2 to [R1 + 5]
1D31 // 21 SUB R13 = R3 - R1
E000 // 22 NOP
8E15 // 23 LW R14 from [R1 + 5]
8432 // 24 LW R4 from [R3 + 2], never stored
A604 // 25 B LT to 30
E000 // 26 NOP
E000 // 27 NOP
E000 // 28 NOP
6E77 // 29 LLB R14, 0x77 skipped
B004 // 30 JAL to 35
E000 // 31 NOP
E000 // 32 NOP
E000 // 33 NOP
D000 // 34 HLT
C0F0 // 35 JR R15
0A51 // 36 ADD R10 = R5 + R1
E000 // 37 NOP
E000 // 38 NOP

// ==== cpu.f ====
common/cpuPkg.sv
fetch/instrFetch.sv
decode/regFile.sv
decode/instrDecode.sv
execute/execute.sv
memory/memAccess.sv
design/cpu.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --x-initial 0 --top-module cpuTb -Mdir obj_dir -f cpu.f

# The ROM and the testbench both load program.hex from the working directory
cd verif
out=$(../obj_dir/VcpuTb)
echo "$out"
echo "$out" | grep -q "^TEST PASSED$"
